// ==== verilog.f ====
hdl/copper_pkg.sv
hdl/copper_ctrl.sv
hdl/copper_decode.sv
hdl/copper_wait.sv
hdl/copper_result.sv
hdl/copper_top.sv
tests/copper_bus_model.sv
tests/copper_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the copper testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module copper_tb -f verilog.f -o copper_sim
./obj_dir/copper_sim 2>&1 | tee sim.log
if grep -q "Test FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== tests/copper_tb.sv ====
// copper coprocessor testbench
// runs table driven copper programs against the bus model and checks every XR write
`default_nettype none
`timescale 1ns/10ps

module copper_tb;

    import copper_pkg::*;

    localparam int NUM_ROWS     = 5;
    localparam int PROG_MAX     = 20;
    localparam int WR_MAX       = 4;
    localparam int TIMEOUT      = 500000;
    localparam int ACK_TIMEOUT  = 16;
    localparam int FRAME_CYCLES = TOTAL_WIDTH * TOTAL_HEIGHT;
    // beam constraint kinds on an expected write
    localparam int C_NONE       = 0;
    localparam int C_H_GE       = 1;
    localparam int C_V_GE       = 2;
    // VPOS past the last line, waits until the frame restart
    localparam word_t HALT      = 16'h2BFF;

    logic        clk;
    logic        cop_reset;
    logic        cop_ctrl_wr;
    logic        cop_ctrl_en;
    hres_t       h_count;
    vres_t       v_count;
    logic        copmem_rd_en;
    copp_addr_t  copmem_rd_addr;
    word_t       copmem_rd_data;
    logic        xr_wr_en;
    logic        xr_wr_ack;
    word_t       xr_wr_addr;
    word_t       xr_wr_data;
    logic        load_en;
    copp_addr_t  load_addr;
    word_t       load_data;
    int unsigned cycle_cnt;

    // stimulus table, one row per behavior
    word_t prog_tab     [NUM_ROWS][PROG_MAX];
    int    prog_len     [NUM_ROWS];
    word_t exp_addr     [NUM_ROWS][WR_MAX];
    word_t exp_data     [NUM_ROWS][WR_MAX];
    int    cons_kind    [NUM_ROWS][WR_MAX];
    int    cons_val     [NUM_ROWS][WR_MAX];
    int    exp_cnt      [NUM_ROWS];
    logic  frame_repeat [NUM_ROWS];

    copper_top uut (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .cop_ctrl_wr_i    (cop_ctrl_wr),
        .cop_ctrl_en_i    (cop_ctrl_en),
        .h_count_i        (h_count),
        .v_count_i        (v_count),
        .copmem_rd_en_o   (copmem_rd_en),
        .copmem_rd_addr_o (copmem_rd_addr),
        .copmem_rd_data_i (copmem_rd_data),
        .xr_wr_en_o       (xr_wr_en),
        .xr_wr_ack_i      (xr_wr_ack),
        .xr_wr_addr_o     (xr_wr_addr),
        .xr_wr_data_o     (xr_wr_data)
    );

    copper_bus_model u_bus (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .load_en_i        (load_en),
        .load_addr_i      (load_addr),
        .load_data_i      (load_data),
        .copmem_rd_en_i   (copmem_rd_en),
        .copmem_rd_addr_i (copmem_rd_addr),
        .copmem_rd_data_o (copmem_rd_data),
        .xr_wr_en_i       (xr_wr_en),
        .xr_wr_ack_o      (xr_wr_ack)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // beam counters, wrap at line and frame end
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (h_count == hres_t'(TOTAL_WIDTH - 1)) begin
            h_count <= '0;
            if (v_count == vres_t'(TOTAL_HEIGHT - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + vres_t'(1);
            end
        end else begin
            h_count <= h_count + hres_t'(1);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic push_word(input int row, input word_t w);
        prog_tab[row][prog_len[row]] = w;
        prog_len[row]++;
    endtask

    // opcode word followed by its operand word
    task automatic push_pair(input int row, input word_t op, input word_t arg);
        push_word(row, op);
        push_word(row, arg);
    endtask

    task automatic expect_write(input int row, input word_t a, input word_t d,
                                input int kind, input int val);
        exp_addr[row][exp_cnt[row]]  = a;
        exp_data[row][exp_cnt[row]]  = d;
        cons_kind[row][exp_cnt[row]] = kind;
        cons_val[row][exp_cnt[row]]  = val;
        exp_cnt[row]++;
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            frame_repeat[r] = 1'b0;
        end
        // SETI writes into several regions, in program order
        push_pair(0, 16'h4010, 16'h1234);
        push_pair(0, 16'h4011, 16'hABCD);
        push_pair(0, 16'h8002, 16'h0F0F);
        push_pair(0, 16'hC3FF, 16'h5555);
        push_word(0, HALT);
        expect_write(0, 16'h4010, 16'h1234, C_NONE, 0);
        expect_write(0, 16'h4011, 16'hABCD, C_NONE, 0);
        expect_write(0, 16'h8002, 16'h0F0F, C_NONE, 0);
        expect_write(0, 16'hC3FF, 16'h5555, C_NONE, 0);
        // SETM from word 9, RA load 0x100, RA_SUB 0x30, SETM from RA
        push_pair(1, 16'h1009, 16'h4020);
        push_pair(1, 16'h0400, 16'h0100);
        push_pair(1, 16'h0401, 16'h0030);
        push_pair(1, 16'h1400, 16'h4021);
        push_word(1, HALT);
        push_word(1, 16'hBEEF);
        expect_write(1, 16'h4020, 16'hBEEF, C_NONE, 0);
        expect_write(1, 16'h4021, 16'h00D0, C_NONE, 0);
        // branches, the 0xDEAD markers must be skipped
        push_pair(2, 16'h0400, 16'h0010);
        // B clear, BRGE taken
        push_word(2, 16'h3005);
        push_pair(2, 16'h4030, 16'hDEAD);
        // 0x10 - 0x20 borrows, B set
        push_pair(2, 16'h0401, 16'h0020);
        push_word(2, 16'h300A);
        // RA 0xFFF0 minus 1, B clear
        push_pair(2, 16'h4031, 16'h0001);
        push_word(2, 16'h380D);
        // RA 0xFFF0 minus 0xFFFF, B set
        push_pair(2, 16'h4032, 16'hFFFF);
        push_word(2, 16'h3811);
        push_pair(2, 16'h4034, 16'hDEAD);
        push_word(2, HALT);
        push_pair(2, 16'h4035, 16'h0005);
        push_word(2, HALT);
        expect_write(2, 16'h4031, 16'h0001, C_NONE, 0);
        expect_write(2, 16'h4032, 16'hFFFF, C_NONE, 0);
        expect_write(2, 16'h4035, 16'h0005, C_NONE, 0);
        // HPOS 400, then VPOS 5
        push_pair(3, 16'h4040, 16'h0001);
        push_word(3, 16'h2190);
        push_pair(3, 16'h4041, 16'h0002);
        push_word(3, 16'h2805);
        push_pair(3, 16'h4042, 16'h0003);
        push_word(3, HALT);
        expect_write(3, 16'h4040, 16'h0001, C_NONE, 0);
        expect_write(3, 16'h4041, 16'h0002, C_H_GE, 400);
        expect_write(3, 16'h4042, 16'h0003, C_V_GE, 5);
        // program reruns after the frame restart
        push_pair(4, 16'h4050, 16'h00A5);
        push_pair(4, 16'h4051, 16'h005A);
        push_word(4, HALT);
        expect_write(4, 16'h4050, 16'h00A5, C_NONE, 0);
        expect_write(4, 16'h4051, 16'h005A, C_NONE, 0);
        frame_repeat[4] = 1'b1;
    endtask

    task automatic set_enable(input logic en);
        @(posedge clk);
        cop_ctrl_wr <= 1'b1;
        cop_ctrl_en <= en;
        @(posedge clk);
        cop_ctrl_wr <= 1'b0;
    endtask

    task automatic load_program(input int row);
        for (int i = 0; i < prog_len[row]; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= copp_addr_t'(i);
            load_data <= prog_tab[row][i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // no memory read and no XR write for a number of cycles
    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("copmem_rd_en_o", 32'(copmem_rd_en), 32'd0);
            check_value("xr_wr_en_o", 32'(xr_wr_en), 32'd0);
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        @(negedge clk);
        while (!(h_count == hres_t'(0) && v_count == vres_t'(0))) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout waiting for the start of a frame");
            end
            @(negedge clk);
        end
    endtask

    // address of the next copper memory read
    task automatic wait_mem_read(output copp_addr_t addr);
        int n;
        n = 0;
        @(negedge clk);
        while (!copmem_rd_en) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout waiting for a copper memory read");
            end
            @(negedge clk);
        end
        addr = copmem_rd_addr;
    endtask

    // capture address, data and beam position when the write appears, then its ack
    task automatic wait_xr_write(output word_t addr, output word_t data,
                                 output hres_t h_at, output vres_t v_at);
        int n;
        n = 0;
        @(negedge clk);
        while (!xr_wr_en) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout waiting for an XR write");
            end
            @(negedge clk);
        end
        addr = xr_wr_addr;
        data = xr_wr_data;
        h_at = h_count;
        v_at = v_count;
        n = 0;
        while (!xr_wr_ack) begin
            n++;
            if (n > ACK_TIMEOUT) begin
                abort_run("timeout waiting for the XR write acknowledge");
            end
            @(negedge clk);
        end
    endtask

    task automatic run_row(input int row);
        word_t       got_addr;
        word_t       got_data;
        hres_t       h_at;
        vres_t       v_at;
        copp_addr_t  rd_addr;
        int unsigned start_cycle;
        set_enable(1'b0);
        load_program(row);
        wait_frame_start();
        start_cycle = cycle_cnt;
        set_enable(1'b1);
        // program starts at word 0
        wait_mem_read(rd_addr);
        check_value("copmem_rd_addr_o", 32'(rd_addr), 32'd0);
        for (int k = 0; k < exp_cnt[row]; k++) begin
            wait_xr_write(got_addr, got_data, h_at, v_at);
            check_value("xr_wr_addr_o", 32'(got_addr), 32'(exp_addr[row][k]));
            check_value("xr_wr_data_o", 32'(got_data), 32'(exp_data[row][k]));
            if (cons_kind[row][k] == C_H_GE && h_at < hres_t'(cons_val[row][k])) begin
                abort_run($sformatf("XR write issued at h_count %0d before HPOS %0d",
                                    h_at, cons_val[row][k]));
            end
            if (cons_kind[row][k] == C_V_GE && v_at < vres_t'(cons_val[row][k])) begin
                abort_run($sformatf("XR write issued at v_count %0d before VPOS %0d",
                                    v_at, cons_val[row][k]));
            end
        end
        if (frame_repeat[row]) begin
            // after the restart the next read is word 0 again
            wait_mem_read(rd_addr);
            check_value("copmem_rd_addr_o", 32'(rd_addr), 32'd0);
            // first write again, at the top of the next frame
            wait_xr_write(got_addr, got_data, h_at, v_at);
            check_value("xr_wr_addr_o", 32'(got_addr), 32'(exp_addr[row][0]));
            check_value("xr_wr_data_o", 32'(got_data), 32'(exp_data[row][0]));
            check_value("v_count", 32'(v_at), 32'd0);
            if (cycle_cnt - start_cycle < FRAME_CYCLES - TOTAL_WIDTH) begin
                abort_run("program restarted before the end of the frame");
            end
        end
    endtask

    initial begin
        // seeds the generator for the whole run
        void'($urandom(32'h37a0));
        clk         = 1'b0;
        cop_reset   = 1'b1;
        cop_ctrl_wr = 1'b0;
        cop_ctrl_en = 1'b0;
        h_count     = '0;
        v_count     = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        cycle_cnt   = 0;
        build_table();
        repeat (16) @(posedge clk);
        cop_reset <= 1'b0;
        // disabled after reset, nothing moves
        check_idle(200);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/copper_bus_model.sv ====
// copper test bus model
// copper memory with one cycle read latency, XR write acknowledge after a random delay
`default_nettype none
`timescale 1ns/10ps

module copper_bus_model (
    input  wire logic                   clk,
    input  wire logic                   cop_reset,
    // program load port, used while the coprocessor is disabled
    input  wire logic                   load_en_i,
    input  wire copper_pkg::copp_addr_t load_addr_i,
    input  wire copper_pkg::word_t      load_data_i,
    // copper memory read port
    input  wire logic                   copmem_rd_en_i,
    input  wire copper_pkg::copp_addr_t copmem_rd_addr_i,
    output copper_pkg::word_t           copmem_rd_data_o,
    // XR bus write handshake
    input  wire logic                   xr_wr_en_i,
    output logic                        xr_wr_ack_o
);

    import copper_pkg::*;

    word_t      mem [0:1023];
    // a write is being counted down
    logic       armed_q;
    logic [1:0] delay_q;
    logic [1:0] pick;

    // unused words decode as VPOS beyond the last line, so a runaway program halts
    function automatic word_t fill_word(input copp_addr_t a);
        return {a[9:8], 4'b1011, 2'b11, a[7:0]};
    endfunction

    initial begin
        for (int a = 0; a < 1024; a++) begin
            mem[a] = fill_word(copp_addr_t'(a));
        end
        copmem_rd_data_o = '0;
        xr_wr_ack_o      = 1'b0;
        armed_q          = 1'b0;
        delay_q          = '0;
        pick             = '0;
    end

    // data valid the cycle after the read enable
    always @(posedge clk) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end
        if (copmem_rd_en_i) begin
            copmem_rd_data_o <= mem[copmem_rd_addr_i];
        end
    end

    always @(posedge clk) begin
        if (cop_reset) begin
            xr_wr_ack_o <= 1'b0;
            armed_q     <= 1'b0;
            delay_q     <= '0;
        end else begin
            xr_wr_ack_o <= 1'b0;
            if (xr_wr_ack_o || !xr_wr_en_i) begin
                armed_q <= 1'b0;
            end else if (!armed_q) begin
                // new write, pick 0 to 3 extra cycles
                pick = 2'($urandom_range(3, 0));
                armed_q <= 1'b1;
                if (pick == 2'd0) begin
                    xr_wr_ack_o <= 1'b1;
                end else begin
                    delay_q <= pick - 2'd1;
                end
            end else if (delay_q == 2'd0) begin
                xr_wr_ack_o <= 1'b1;
            end else begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/copper_top.sv ====
// copper display coprocessor
// runs a copper program in step with the beam and writes the XR register bus
`default_nettype none
`timescale 1ns/10ps

module copper_top (
    input  wire logic                   clk,
    input  wire logic                   cop_reset,
    input  wire logic                   cop_ctrl_wr_i,
    input  wire logic                   cop_ctrl_en_i,
    input  wire copper_pkg::hres_t      h_count_i,
    input  wire copper_pkg::vres_t      v_count_i,
    output logic                        copmem_rd_en_o,
    output copper_pkg::copp_addr_t      copmem_rd_addr_o,
    input  wire copper_pkg::word_t      copmem_rd_data_i,
    output logic                        xr_wr_en_o,
    input  wire logic                   xr_wr_ack_i,
    output copper_pkg::word_t           xr_wr_addr_o,
    output copper_pkg::word_t           xr_wr_data_o
);

    import copper_pkg::*;

    // restart level from the control register
    logic  restart;

    // beam wait handshake
    logic  wait_start;
    logic  wait_for_v;
    hres_t wait_val;
    logic  waiting;

    // write requests to the result unit
    logic  wr_req;
    word_t wr_addr;
    word_t wr_data;
    logic  wr_busy;
    word_t ra;
    logic  borrow;

    copper_ctrl u_ctrl (
        .clk           (clk),
        .cop_reset     (cop_reset),
        .cop_ctrl_wr_i (cop_ctrl_wr_i),
        .cop_ctrl_en_i (cop_ctrl_en_i),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .restart_o     (restart)
    );

    copper_decode u_decode (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .restart_i        (restart),
        .copmem_rd_data_i (copmem_rd_data_i),
        .waiting_i        (waiting),
        .wr_busy_i        (wr_busy),
        .ra_i             (ra),
        .borrow_i         (borrow),
        .copmem_rd_en_o   (copmem_rd_en_o),
        .copmem_rd_addr_o (copmem_rd_addr_o),
        .wait_start_o     (wait_start),
        .wait_for_v_o     (wait_for_v),
        .wait_val_o       (wait_val),
        .wr_req_o         (wr_req),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data)
    );

    copper_wait u_wait (
        .clk          (clk),
        .cop_reset    (cop_reset),
        .restart_i    (restart),
        .wait_start_i (wait_start),
        .wait_for_v_i (wait_for_v),
        .wait_val_i   (wait_val),
        .h_count_i    (h_count_i),
        .v_count_i    (v_count_i),
        .waiting_o    (waiting)
    );

    copper_result u_result (
        .clk          (clk),
        .cop_reset    (cop_reset),
        .restart_i    (restart),
        .wr_req_i     (wr_req),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .xr_wr_ack_i  (xr_wr_ack_i),
        .xr_wr_en_o   (xr_wr_en_o),
        .xr_wr_addr_o (xr_wr_addr_o),
        .xr_wr_data_o (xr_wr_data_o),
        .wr_busy_o    (wr_busy),
        .ra_o         (ra),
        .borrow_o     (borrow)
    );

endmodule

`default_nettype wire

// ==== hdl/copper_result.sv ====
// copper result unit
// RA register and borrow flag, routes each write to RA or out on the XR bus
`default_nettype none
`timescale 1ns/10ps

module copper_result (
    input  wire logic              clk,
    input  wire logic              cop_reset,
    input  wire logic              restart_i,
    input  wire logic              wr_req_i,
    input  wire copper_pkg::word_t wr_addr_i,
    input  wire copper_pkg::word_t wr_data_i,
    input  wire logic              xr_wr_ack_i,
    output logic                   xr_wr_en_o,
    output copper_pkg::word_t      xr_wr_addr_o,
    output copper_pkg::word_t      xr_wr_data_o,
    output logic                   wr_busy_o,
    output copper_pkg::word_t      ra_o,
    output logic                   borrow_o
);

    import copper_pkg::*;

    // write targets the RA pseudo register
    logic        is_ra;
    // RA minus written value, bit 16 is the borrow
    logic [16:0] sub_full;

    assign is_ra    = (wr_addr_i[15:14] == XR_REGION_CONFIG) && wr_addr_i[COP_XREG_BIT];
    assign sub_full = {1'b0, ra_o} - {1'b0, wr_data_i};

    always_ff @(posedge clk) begin
        if (cop_reset || restart_i) begin
            ra_o       <= '0;
            borrow_o   <= 1'b0;
            xr_wr_en_o <= 1'b0;
        end else begin
            // drop the XR write once acknowledged
            if (xr_wr_en_o && xr_wr_ack_i) begin
                xr_wr_en_o <= 1'b0;
            end

            if (wr_req_i) begin
                // every write compares against the old RA
                borrow_o <= sub_full[16];
                if (is_ra) begin
                    if (wr_addr_i[COP_SUB_BIT]) begin
                        // RA_SUB
                        ra_o <= sub_full[15:0];
                    end else begin
                        // plain RA load clears B
                        ra_o     <= wr_data_i;
                        borrow_o <= 1'b0;
                    end
                end else begin
                    xr_wr_en_o <= 1'b1;
                end
            end
        end
    end

    // XR address and data held until the ack
    always_ff @(posedge clk) begin
        if (wr_req_i && !is_ra) begin
            xr_wr_addr_o <= wr_addr_i;
            xr_wr_data_o <= wr_data_i;
        end
    end

    assign wr_busy_o = xr_wr_en_o;

    // bus request must not change or vanish before the ack
    a_xr_stable: assert property (
        @(posedge clk) disable iff (cop_reset || restart_i)
        (xr_wr_en_o && !xr_wr_ack_i) |=>
            (xr_wr_en_o && $stable(xr_wr_addr_o) && $stable(xr_wr_data_o))
    ) else $error("XR write changed before acknowledge");

endmodule

`default_nettype wire

// ==== hdl/copper_wait.sv ====
// copper beam wait unit
// holds the sequencer until the selected beam counter reaches the HPOS or VPOS target
`default_nettype none
`timescale 1ns/10ps

module copper_wait (
    input  wire logic              clk,
    input  wire logic              cop_reset,
    input  wire logic              restart_i,
    input  wire logic              wait_start_i,
    input  wire logic              wait_for_v_i,
    input  wire copper_pkg::hres_t wait_val_i,
    input  wire copper_pkg::hres_t h_count_i,
    input  wire copper_pkg::vres_t v_count_i,
    output logic                   waiting_o
);

    import copper_pkg::*;

    // latched target and counter select
    hres_t wait_val_q;
    logic  for_v_q;
    logic  hit;

    // compare against the selected beam counter
    assign hit = for_v_q ? (v_count_i >= vres_t'(wait_val_q)) : (h_count_i >= wait_val_q);

    always_ff @(posedge clk) begin
        if (wait_start_i) begin
            wait_val_q <= wait_val_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cop_reset || restart_i) begin
            waiting_o <= 1'b0;
            for_v_q   <= 1'b0;
        end else if (wait_start_i) begin
            waiting_o <= 1'b1;
            for_v_q   <= wait_for_v_i;
        end else if (waiting_o && hit) begin
            waiting_o <= 1'b0;
        end
    end

    // sequencer stays in fetch until the previous wait has ended
    a_no_restart_while_waiting: assert property (
        @(posedge clk) disable iff (cop_reset || restart_i)
        wait_start_i |-> !waiting_o
    ) else $error("copper wait started while already waiting");

endmodule

`default_nettype wire

// ==== hdl/copper_decode.sv ====
// copper sequencer
// fetches and decodes copper program words, issues XR writes, beam waits and branches
`default_nettype none
`timescale 1ns/10ps

module copper_decode (
    input  wire logic                   clk,
    input  wire logic                   cop_reset,
    input  wire logic                   restart_i,
    input  wire copper_pkg::word_t      copmem_rd_data_i,
    input  wire logic                   waiting_i,
    input  wire logic                   wr_busy_i,
    input  wire copper_pkg::word_t      ra_i,
    input  wire logic                   borrow_i,
    output logic                        copmem_rd_en_o,
    output copper_pkg::copp_addr_t      copmem_rd_addr_o,
    output logic                        wait_start_o,
    output logic                        wait_for_v_o,
    output copper_pkg::hres_t           wait_val_o,
    output logic                        wr_req_o,
    output copper_pkg::word_t           wr_addr_o,
    output copper_pkg::word_t           wr_data_o
);

    import copper_pkg::*;

    copp_state_t state_q;
    // program counter, always points at the next word to read
    copp_addr_t  pc_q;
    // opcode of the executing instruction
    word_t       ir_q;
    // memory data valid this cycle
    logic        rd_valid_q;
    // last memory word, kept across write stalls
    word_t       mem_hold_q;
    // SETI operand already arrived while stalled
    logic        arg_ready_q;

    word_t       mem_word;
    logic        arg_ok;
    logic        br_taken;
    copp_addr_t  pc_next;

    // live data in its valid cycle, held copy afterwards
    assign mem_word = rd_valid_q ? copmem_rd_data_i : mem_hold_q;
    assign arg_ok   = rd_valid_q | arg_ready_q;
    assign pc_next  = pc_q + 1'b1;
    // BRGE when B clear, BRLT when B set
    assign br_taken = (borrow_i == ir_q[ARG_BIT]);

    always_ff @(posedge clk) begin
        if (rd_valid_q) begin
            mem_hold_q <= copmem_rd_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cop_reset || restart_i) begin
            state_q          <= ST_FETCH;
            pc_q             <= '0;
            ir_q             <= '0;
            rd_valid_q       <= 1'b0;
            arg_ready_q      <= 1'b0;
            copmem_rd_en_o   <= 1'b0;
            copmem_rd_addr_o <= '0;
            wait_start_o     <= 1'b0;
            wait_for_v_o     <= 1'b0;
            wait_val_o       <= '0;
            wr_req_o         <= 1'b0;
            wr_addr_o        <= '0;
            wr_data_o        <= '0;
        end else begin
            // strobes default low
            copmem_rd_en_o <= 1'b0;
            wait_start_o   <= 1'b0;
            wr_req_o       <= 1'b0;
            rd_valid_q     <= copmem_rd_en_o;

            case (state_q)
                ST_FETCH: begin
                    if (!rd_valid_q) begin
                        // read at PC unless a read or a beam wait is in progress
                        if (!copmem_rd_en_o && !waiting_i && !wait_start_o) begin
                            copmem_rd_en_o   <= 1'b1;
                            copmem_rd_addr_o <= pc_q;
                            pc_q             <= pc_next;
                        end
                    end else begin
                        ir_q        <= copmem_rd_data_i;
                        arg_ready_q <= 1'b0;
                        // SETI and SETM carry a second word, read it now
                        if (!copmem_rd_data_i[13]) begin
                            copmem_rd_en_o   <= 1'b1;
                            copmem_rd_addr_o <= pc_q;
                            pc_q             <= pc_next;
                        end
                        state_q <= ST_DECODE;
                    end
                end

                ST_DECODE: begin
                    case (copp_opcode_t'(ir_q[13:12]))
                        OP_SETI: begin
                            if (arg_ok && !wr_busy_i) begin
                                // opcode word doubles as the XR address
                                wr_req_o         <= 1'b1;
                                wr_addr_o        <= ir_q;
                                wr_data_o        <= mem_word;
                                // pre-read the next opcode
                                copmem_rd_en_o   <= 1'b1;
                                copmem_rd_addr_o <= pc_q;
                                pc_q             <= pc_next;
                                state_q          <= ST_FETCH;
                            end else if (rd_valid_q) begin
                                arg_ready_q <= 1'b1;
                            end
                        end
                        OP_MOVE: begin
                            // source read, unused when the source is RA
                            copmem_rd_en_o   <= 1'b1;
                            copmem_rd_addr_o <= ir_q[9:0];
                            state_q          <= ST_SETM_RD;
                        end
                        OP_HVPOS: begin
                            wait_start_o <= 1'b1;
                            wait_for_v_o <= ir_q[ARG_BIT];
                            wait_val_o   <= ir_q[9:0];
                            state_q      <= ST_FETCH;
                        end
                        OP_BRCC: begin
                            if (br_taken) begin
                                pc_q <= ir_q[9:0];
                            end
                            state_q <= ST_FETCH;
                        end
                        default: begin
                            state_q <= ST_FETCH;
                        end
                    endcase
                end

                ST_SETM_RD: begin
                    // second SETM word is the XR destination
                    wr_addr_o <= copmem_rd_data_i;
                    state_q   <= ST_SETM_WR;
                end

                ST_SETM_WR: begin
                    if (!wr_busy_i) begin
                        wr_req_o         <= 1'b1;
                        wr_data_o        <= ir_q[COP_XREG_BIT] ? ra_i : mem_word;
                        copmem_rd_en_o   <= 1'b1;
                        copmem_rd_addr_o <= pc_q;
                        pc_q             <= pc_next;
                        state_q          <= ST_FETCH;
                    end
                end

                default: begin
                    state_q <= ST_FETCH;
                end
            endcase
        end
    end

    // a request must never land on a pending XR write
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (cop_reset || restart_i)
        wr_req_o |-> !wr_busy_i
    ) else $error("copper write request while XR write pending");

endmodule

`default_nettype wire

// ==== hdl/copper_ctrl.sv ====
// copper control register
// holds the enable bit and raises restart while disabled or just before each frame
`default_nettype none
`timescale 1ns/10ps

module copper_ctrl (
    input  wire logic              clk,
    input  wire logic              cop_reset,
    input  wire logic              cop_ctrl_wr_i,
    input  wire logic              cop_ctrl_en_i,
    input  wire copper_pkg::hres_t h_count_i,
    input  wire copper_pkg::vres_t v_count_i,
    output logic                   restart_o
);

    import copper_pkg::*;

    // enable bit, cleared by reset
    logic cop_en_q;
    // one cycle pulse after the restart point
    logic sof_q;
    // beam sits at the restart point this cycle
    logic at_restart;

    assign at_restart = (h_count_i == hres_t'(RESTART_H)) &&
                        (v_count_i == vres_t'(TOTAL_HEIGHT - 1));

    always_ff @(posedge clk) begin
        if (cop_reset) begin
            cop_en_q <= 1'b0;
            sof_q    <= 1'b0;
        end else begin
            // control write, takes effect next cycle
            if (cop_ctrl_wr_i) begin
                cop_en_q <= cop_ctrl_en_i;
            end
            sof_q <= at_restart;
        end
    end

    // held in restart while disabled, pulsed once per frame otherwise
    assign restart_o = ~cop_en_q | sof_q;

endmodule

`default_nettype wire

// ==== hdl/copper_pkg.sv ====
// copper coprocessor shared definitions
// word and address types, opcode and sequencer encodings, video timing
`default_nettype none

package copper_pkg;

    // basic bus widths
    typedef logic [15:0] word_t;
    typedef logic [9:0]  copp_addr_t;
    typedef logic [9:0]  hres_t;
    typedef logic [9:0]  vres_t;

    // opcode field, instruction bits 13:12
    // SETI  xx00 aaaa aaaa aaaa + im16
    // SETM  --01 -rcc cccc cccc + xadr16
    // HPOS  --10 0-ii iiii iiii, VPOS with bit 11 set
    // BRGE  --11 0rcc cccc cccc, BRLT with bit 11 set
    typedef enum logic [1:0] {
        OP_SETI  = 2'b00,
        OP_MOVE  = 2'b01,
        OP_HVPOS = 2'b10,
        OP_BRCC  = 2'b11
    } copp_opcode_t;

    // sequencer states
    typedef enum logic [1:0] {
        // idle, waiting on beam, or reading the next opcode
        ST_FETCH   = 2'b00,
        ST_DECODE  = 2'b01,
        // SETM destination word arriving
        ST_SETM_RD = 2'b10,
        // SETM source word arriving, write issued
        ST_SETM_WR = 2'b11
    } copp_state_t;

    // XR region code in address bits 15:14
    localparam logic [1:0] XR_REGION_CONFIG = 2'b00;

    // pseudo register select, RA read or RA/RA_SUB write
    localparam int COP_XREG_BIT = 10;
    // 0 loads RA, 1 subtracts from RA
    localparam int COP_SUB_BIT  = 0;
    // VPOS over HPOS, BRLT over BRGE
    localparam int ARG_BIT      = 11;

    // video frame geometry
    localparam int TOTAL_WIDTH  = 800;
    localparam int TOTAL_HEIGHT = 525;
    // program restarts a few pixels before the end of the last line
    localparam int RESTART_H    = TOTAL_WIDTH - 4;

endpackage

`default_nettype wire
